// File: list.f
logic/bus_ctrl_pkg.sv
logic/menu_fsm.sv
logic/write_data_bank.sv
logic/config_sequencer.sv
logic/bus_ctrl_top.sv
test/master_model.sv
test/tb_bus_ctrl.sv

// File: logic/bus_ctrl_pkg.sv
`default_nettype none

package bus_ctrl_pkg;

    localparam int MASTER_COUNT = 2;
    localparam int SLAVE_COUNT = 3;
    localparam int DATA_WIDTH = 16;                                 // data word and switch word
    localparam int SLAVE_DEPTHS [SLAVE_COUNT] = '{4096, 4096, 2048}; // slave ids 1..3
    localparam int ADDR_WIDTH = 12;                                 // fits the deepest slave
    localparam int SLAVE_ID_WIDTH = 2;
    localparam int BANK_DEPTH = 16;                                 // entry words per master
    localparam int BANK_ADDR_WIDTH = 4;
    localparam int CONFIG_CLK_COUNT = 2;                            // cycles per config word
    localparam int MASTER_IDX_WIDTH = $clog2(MASTER_COUNT);

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [SLAVE_ID_WIDTH-1:0] slave_id_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] count_t;
    typedef logic [MASTER_IDX_WIDTH-1:0] master_idx_t;

    typedef enum logic [3:0] {
        master_slave_sel,
        read_write_sel,
        external_write_sel,
        external_write_m1,
        external_write_m1_2,       // master 1 entry, then master 2
        external_write_m2,
        slave_addr_sel_m1,
        slave_addr_sel_m2,
        addr_count_sel_m1,
        addr_count_sel_m2,
        config_masters,
        communication_ready,
        communicating,
        communication_done         // held until reset
    } menu_state_t;

    typedef enum logic [1:0] {
        config_start,
        config_middle,
        config_last,
        config_done
    } config_state_t;

    // command bus of one master
    typedef struct packed {
        logic      burst;
        logic      rd_wr;
        logic      in_ex;
        word_t     data;
        addr_t     address;
        slave_id_t slave_id;
        logic      start;
    } master_cmd_t;

    typedef struct packed {
        logic      rd_wr;
        logic      in_ex;
        logic      burst;
        slave_id_t slave_id;
        addr_t     first_addr;
        addr_t     last_addr;
    } master_setup_t;

endpackage

`default_nettype wire

// File: logic/bus_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module bus_ctrl_top (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      step,
    input  logic                      addr_step,
    input  bus_ctrl_pkg::word_t       sw,
    input  logic [bus_ctrl_pkg::MASTER_COUNT-1:0] done_com,
    input  bus_ctrl_pkg::word_t [bus_ctrl_pkg::MASTER_COUNT-1:0] data_out,
    output bus_ctrl_pkg::master_cmd_t [bus_ctrl_pkg::MASTER_COUNT-1:0] cmd,
    output bus_ctrl_pkg::word_t [bus_ctrl_pkg::MASTER_COUNT-1:0] read_data,
    output logic                      at_start,
    output logic                      config_ready,
    output logic                      comm_done
);
    import bus_ctrl_pkg::*;

    menu_state_t                    state;
    master_setup_t [MASTER_COUNT-1:0] setup;
    count_t [MASTER_COUNT-1:0]      bank_count;
    master_idx_t                    rd_master;
    count_t                         rd_index;
    word_t                          rd_data;
    logic                           conf_done;

    menu_fsm u_menu_fsm (
        .clk       (clk),
        .rstN      (rstN),
        .step      (step),
        .sw        (sw),
        .conf_done (conf_done),
        .done_com  (done_com),
        .state     (state),
        .setup     (setup)
    );

    write_data_bank u_write_data_bank (
        .clk        (clk),
        .rstN       (rstN),
        .state      (state),
        .sw         (sw),
        .addr_step  (addr_step),
        .step       (step),
        .rd_master  (rd_master),
        .rd_index   (rd_index),
        .rd_data    (rd_data),
        .bank_count (bank_count)
    );

    config_sequencer u_config_sequencer (
        .clk        (clk),
        .rstN       (rstN),
        .state      (state),
        .step       (step),
        .addr_step  (addr_step),
        .sw         (sw),
        .setup      (setup),
        .bank_count (bank_count),
        .rd_data    (rd_data),
        .rd_master  (rd_master),
        .rd_index   (rd_index),
        .conf_done  (conf_done),
        .done_com   (done_com),
        .data_out   (data_out),
        .cmd        (cmd),
        .read_data  (read_data)
    );

    assign at_start = (state == master_slave_sel);
    assign config_ready = (state == communication_ready);  // masters configured
    assign comm_done = (state == communication_done);

endmodule

`default_nettype wire

// File: logic/config_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module config_sequencer (
    input  logic                        clk,
    input  logic                        rstN,
    input  bus_ctrl_pkg::menu_state_t   state,
    input  logic                        step,
    input  logic                        addr_step,
    input  bus_ctrl_pkg::word_t         sw,
    input  bus_ctrl_pkg::master_setup_t [bus_ctrl_pkg::MASTER_COUNT-1:0] setup,
    input  bus_ctrl_pkg::count_t [bus_ctrl_pkg::MASTER_COUNT-1:0] bank_count,
    input  bus_ctrl_pkg::word_t         rd_data,
    output bus_ctrl_pkg::master_idx_t   rd_master,
    output bus_ctrl_pkg::count_t        rd_index,
    output logic                        conf_done,
    input  logic [bus_ctrl_pkg::MASTER_COUNT-1:0] done_com,
    input  bus_ctrl_pkg::word_t [bus_ctrl_pkg::MASTER_COUNT-1:0] data_out,
    output bus_ctrl_pkg::master_cmd_t [bus_ctrl_pkg::MASTER_COUNT-1:0] cmd,
    output bus_ctrl_pkg::word_t [bus_ctrl_pkg::MASTER_COUNT-1:0] read_data
);
    import bus_ctrl_pkg::*;

    config_state_t                cfg_state;
    master_idx_t                  cfg_master;
    master_idx_t                  next_master;
    logic [$clog2(CONFIG_CLK_COUNT)-1:0] clk_cnt;
    count_t                       word_cnt;
    count_t                       next_word;
    count_t                       last_word;       // index of word W-1
    logic                         step_end;        // last cycle of a config word
    logic [MASTER_COUNT-1:0]      start_q;
    word_t [MASTER_COUNT-1:0]     data_q;
    addr_t [MASTER_COUNT-1:0]     addr_q;

    assign next_master = cfg_master + 1'b1;
    assign next_word = word_cnt + 1'b1;
    assign step_end = (clk_cnt == CONFIG_CLK_COUNT - 1);
    assign conf_done = (cfg_state == config_done);

    always_comb begin
        if (!setup[cfg_master].in_ex || (bank_count[cfg_master] <= count_t'(2)))
            last_word = count_t'(1);             // two words
        else
            last_word = bank_count[cfg_master] - 1'b1;
    end

    // bank word loaded at the next word boundary
    always_comb begin
        rd_master = cfg_master;
        rd_index = next_word;
        if (state == addr_count_sel_m2) begin
            rd_master = '0;
            rd_index = '0;
        end else if (cfg_state == config_last) begin
            rd_master = next_master;
            rd_index = '0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg_state <= config_start;
            cfg_master <= '0;
            clk_cnt <= '0;
            word_cnt <= '0;
            start_q <= '0;
            data_q <= '0;
            addr_q <= '0;
        end else begin
            start_q <= '0;                      // every start is a single cycle
            case (state)
                addr_count_sel_m2:
                    if (step) begin
                        cfg_state <= config_start;
                        cfg_master <= '0;
                        clk_cnt <= '0;
                        word_cnt <= '0;
                        start_q[0] <= 1'b1;
                        data_q[0] <= rd_data;
                        addr_q[0] <= setup[0].first_addr;
                    end
                config_masters: begin
                    clk_cnt <= step_end ? '0 : clk_cnt + 1'b1;
                    case (cfg_state)
                        config_start, config_middle:
                            if (step_end) begin
                                word_cnt <= next_word;
                                data_q[cfg_master] <= rd_data;
                                if (next_word == last_word) begin
                                    cfg_state <= config_last;
                                    start_q[cfg_master] <= 1'b1;
                                    addr_q[cfg_master] <= setup[cfg_master].last_addr; // range end
                                end else begin
                                    cfg_state <= config_middle;
                                end
                            end
                        config_last:
                            if (step_end) begin
                                if (cfg_master == master_idx_t'(MASTER_COUNT - 1)) begin
                                    cfg_state <= config_done;
                                end else begin
                                    cfg_state <= config_start;
                                    cfg_master <= next_master;
                                    word_cnt <= '0;
                                    start_q[next_master] <= 1'b1;
                                    data_q[next_master] <= rd_data;
                                    addr_q[next_master] <= setup[next_master].first_addr;
                                end
                            end
                        default: begin
                        end
                    endcase
                end
                communication_ready:
                    if (step)
                        start_q <= '1;          // all masters together
                communicating:
                    for (int i = 0; i < MASTER_COUNT; i++)
                        if (done_com[i])
                            addr_q[i] <= '0;    // readback begins at word 0
                communication_done:
                    if (addr_step)
                        addr_q <= {MASTER_COUNT{sw[ADDR_WIDTH-1:0]}};
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        read_data <= data_out;
    end

    always_comb begin
        for (int i = 0; i < MASTER_COUNT; i++) begin
            cmd[i].burst = setup[i].burst;
            cmd[i].rd_wr = setup[i].rd_wr;
            cmd[i].in_ex = setup[i].in_ex;
            cmd[i].data = data_q[i];
            cmd[i].address = addr_q[i];
            cmd[i].slave_id = setup[i].slave_id;
            cmd[i].start = start_q[i];
        end
    end

    for (genvar g = 0; g < MASTER_COUNT; g++) begin : g_start_check
        assert property (@(posedge clk) disable iff (!rstN)
            cmd[g].start |=> !cmd[g].start);
    end

endmodule

`default_nettype wire

// File: logic/menu_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module menu_fsm (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        step,
    input  bus_ctrl_pkg::word_t         sw,
    input  logic                        conf_done,
    input  logic [bus_ctrl_pkg::MASTER_COUNT-1:0] done_com,
    output bus_ctrl_pkg::menu_state_t   state,
    output bus_ctrl_pkg::master_setup_t [bus_ctrl_pkg::MASTER_COUNT-1:0] setup
);
    import bus_ctrl_pkg::*;

    menu_state_t next_state;
    master_idx_t cur_master;    // master addressed by the address and length menus

    // range end clamped to the last word of the chosen slave
    function automatic addr_t clamp_last(input addr_t first, input addr_t len,
                                         input slave_id_t id);
        logic [ADDR_WIDTH:0] sum;
        int depth;
        sum = {1'b0, first} + {1'b0, len};
        depth = (id == '0) ? SLAVE_DEPTHS[0] : SLAVE_DEPTHS[id - 1'b1];
        if (sum >= depth)
            return addr_t'(depth - 1);
        else
            return sum[ADDR_WIDTH-1:0];
    endfunction

    assign cur_master = master_idx_t'((state == slave_addr_sel_m2) ||
                                      (state == addr_count_sel_m2));

    always_comb begin
        next_state = state;
        case (state)
            master_slave_sel:
                if (step)
                    next_state = read_write_sel;
            read_write_sel:
                if (step)
                    next_state = (sw[1:0] == 2'b00) ? slave_addr_sel_m1 : external_write_sel;
            external_write_sel:
                if (step) begin
                    case (sw[1:0])
                        2'b01:   next_state = external_write_m1;
                        2'b10:   next_state = external_write_m2;
                        2'b11:   next_state = external_write_m1_2;
                        default: next_state = slave_addr_sel_m1;   // no bank entry
                    endcase
                end
            external_write_m1:
                if (step)
                    next_state = slave_addr_sel_m1;
            external_write_m1_2:
                if (step)
                    next_state = external_write_m2;
            external_write_m2:
                if (step)
                    next_state = slave_addr_sel_m1;
            slave_addr_sel_m1:
                if (step)
                    next_state = slave_addr_sel_m2;
            slave_addr_sel_m2:
                if (step)
                    next_state = addr_count_sel_m1;
            addr_count_sel_m1:
                if (step)
                    next_state = addr_count_sel_m2;
            addr_count_sel_m2:
                if (step)
                    next_state = config_masters;
            config_masters:
                if (conf_done)
                    next_state = communication_ready;
            communication_ready:
                if (step)
                    next_state = communicating;
            communicating:
                if (&done_com)
                    next_state = communication_done;
            default:
                next_state = state;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= master_slave_sel;
            setup <= '0;
        end else begin
            state <= next_state;
            case (state)
                master_slave_sel:
                    for (int i = 0; i < MASTER_COUNT; i++)
                        setup[i].slave_id <= sw[SLAVE_ID_WIDTH*i +: SLAVE_ID_WIDTH];
                read_write_sel:
                    for (int i = 0; i < MASTER_COUNT; i++) begin
                        setup[i].rd_wr <= sw[i];
                        setup[i].in_ex <= 1'b0;     // set again only if the branch is taken
                    end
                external_write_sel:
                    for (int i = 0; i < MASTER_COUNT; i++)
                        setup[i].in_ex <= sw[i];
                slave_addr_sel_m1, slave_addr_sel_m2:
                    setup[cur_master].first_addr <= sw[ADDR_WIDTH-1:0];
                addr_count_sel_m1, addr_count_sel_m2: begin
                    setup[cur_master].burst <= (sw[ADDR_WIDTH-1:0] != '0);  // zero length is single
                    setup[cur_master].last_addr <= clamp_last(setup[cur_master].first_addr,
                                                              sw[ADDR_WIDTH-1:0],
                                                              setup[cur_master].slave_id);
                end
                default: begin
                end
            endcase
        end
    end

    // a master cannot be configured toward slave 0
    for (genvar g = 0; g < MASTER_COUNT; g++) begin : g_id_check
        assert property (@(posedge clk) disable iff (!rstN)
            (state == config_masters) |-> (setup[g].slave_id != '0));
    end

endmodule

`default_nettype wire

// File: logic/write_data_bank.sv
`timescale 1ns/1ns
`default_nettype none

module write_data_bank (
    input  logic                      clk,
    input  logic                      rstN,
    input  bus_ctrl_pkg::menu_state_t state,
    input  bus_ctrl_pkg::word_t       sw,
    input  logic                      addr_step,
    input  logic                      step,
    input  bus_ctrl_pkg::master_idx_t rd_master,
    input  bus_ctrl_pkg::count_t      rd_index,
    output bus_ctrl_pkg::word_t       rd_data,
    output bus_ctrl_pkg::count_t [bus_ctrl_pkg::MASTER_COUNT-1:0] bank_count
);
    import bus_ctrl_pkg::*;

    word_t       mem [MASTER_COUNT][BANK_DEPTH];
    count_t      wr_addr;       // shared by both masters' entry states
    logic        wr_en;
    master_idx_t wr_master;

    assign wr_en = (state == external_write_m1) || (state == external_write_m1_2) ||
                   (state == external_write_m2);
    assign wr_master = master_idx_t'(state == external_write_m2);

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_master][wr_addr] <= sw;      // follows the switches until the next strobe
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wr_addr <= '0;
            bank_count <= '0;
        end else if (wr_en) begin
            if (step) begin
                wr_addr <= '0;                  // next master starts at word 0
            end else if (addr_step) begin
                wr_addr <= wr_addr + 1'b1;
                bank_count[wr_master] <= bank_count[wr_master] + 1'b1;
            end
        end
    end

    assign rd_data = mem[rd_master][rd_index];

    for (genvar g = 0; g < MASTER_COUNT; g++) begin : g_count_check
        assert property (@(posedge clk) disable iff (!rstN)
            (bank_count[g] == count_t'(BANK_DEPTH - 1)) |=> (bank_count[g] != '0));
    end

endmodule

`default_nettype wire

// File: test/master_model.sv
`timescale 1ns/1ns
`default_nettype none

module master_model #(
    parameter int ID = 0,
    parameter int DONE_DELAY = 4
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  bus_ctrl_pkg::master_cmd_t cmd,
    output logic                      done,
    output bus_ctrl_pkg::word_t       data_out,
    output bus_ctrl_pkg::addr_t       range_first,
    output bus_ctrl_pkg::addr_t       range_last
);
    import bus_ctrl_pkg::*;

    int start_seen;     // two config starts, then the run start
    int wait_cnt;

    assign data_out = {4'(ID + 1), cmd.address};    // model number above the address

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            start_seen <= 0;
            wait_cnt <= 0;
            done <= 1'b0;
            range_first <= '0;
            range_last <= '0;
        end else if (cmd.start) begin
            start_seen <= start_seen + 1;
            wait_cnt <= 0;
            done <= 1'b0;
            if (start_seen == 0)
                range_first <= cmd.address;
            if (start_seen == 1)
                range_last <= cmd.address;
        end else if (start_seen >= 3 && !done) begin
            wait_cnt <= wait_cnt + 1;
            if (wait_cnt == DONE_DELAY - 1)
                done <= 1'b1;           // held until the next start
        end
    end

endmodule

`default_nettype wire

// File: test/tb_bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bus_ctrl;
    import bus_ctrl_pkg::*;

    typedef enum logic [1:0] {plain_row, config_row, comm_row, readback_row} row_kind_t;

    typedef struct packed {
        word_t      sw;
        logic       use_addr;       // addr_step instead of step
        row_kind_t  kind;
        logic [2:0] status;         // at_start, config_ready, comm_done afterwards
    } row_t;

    logic clk;
    logic rstN;
    logic step;
    logic addr_step;
    word_t sw;
    logic [MASTER_COUNT-1:0] done_com;
    word_t [MASTER_COUNT-1:0] data_out;
    master_cmd_t [MASTER_COUNT-1:0] cmd;
    word_t [MASTER_COUNT-1:0] read_data;
    logic at_start;
    logic config_ready;
    logic comm_done;
    addr_t [MASTER_COUNT-1:0] range_first;
    addr_t [MASTER_COUNT-1:0] range_last;

    row_t rows [16];
    word_t bank [4];                // entry words of master 0
    master_setup_t [MASTER_COUNT-1:0] exp_setup;
    int w_cnt [MASTER_COUNT];       // config words per master
    int errors;
    logic [15:0] lfsr;

    bus_ctrl_top u_dut (.*);

    for (genvar g = 0; g < MASTER_COUNT; g++) begin : g_master
        master_model #(.ID(g), .DONE_DELAY(3 + 6 * g)) u_master (   // master 1 finishes later
            .clk         (clk),
            .rstN        (rstN),
            .cmd         (cmd[g]),
            .done        (done_com[g]),
            .data_out    (data_out[g]),
            .range_first (range_first[g]),
            .range_last  (range_last[g])
        );
    end

    always #50 clk = ~clk;

    function automatic word_t random_word();
        word_t w;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            w = {w[DATA_WIDTH-2:0], lfsr[0]};
        end
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("FAIL %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR %0t ns: %s", $time, what);
    endtask

    task automatic apply_strobe(input row_t r);
        @(posedge clk);
        sw <= r.sw;
        step <= !r.use_addr;
        addr_step <= r.use_addr;
        @(posedge clk);
        step <= 1'b0;
        addr_step <= 1'b0;
    endtask

    task automatic check_config();
        int cyc;
        int base;
        logic exp_start;
        for (cyc = 0; cyc < 40; cyc++) begin
            @(negedge clk);
            if (config_ready)
                break;
            for (int m = 0; m < MASTER_COUNT; m++) begin
                base = (m == 0) ? 0 : 2 * w_cnt[0];
                exp_start = (cyc == base) || (cyc == base + 2 * (w_cnt[m] - 1));
                if (cmd[m].start !== exp_start)
                    report_mismatch($sformatf("cmd[%0d].start", m), cmd[m].start, exp_start);
                if (cmd[m].start && {cmd[m].slave_id, cmd[m].rd_wr, cmd[m].in_ex, cmd[m].burst}
                        !== {exp_setup[m].slave_id, exp_setup[m].rd_wr, exp_setup[m].in_ex,
                             exp_setup[m].burst})
                    report_mismatch($sformatf("cmd[%0d].{slave_id,rd_wr,in_ex,burst}", m),
                                    {cmd[m].slave_id, cmd[m].rd_wr, cmd[m].in_ex, cmd[m].burst},
                                    {exp_setup[m].slave_id, exp_setup[m].rd_wr,
                                     exp_setup[m].in_ex, exp_setup[m].burst});
            end
            if (cyc < 2 * w_cnt[0] && cmd[0].data !== bank[cyc / 2])   // two cycles per word
                report_mismatch("cmd[0].data", cmd[0].data, bank[cyc / 2]);
        end
        if (cyc != 2 * (w_cnt[0] + w_cnt[1]) + 1)
            report_error($sformatf("config_ready seen after %0d cycles, expected %0d",
                                   cyc, 2 * (w_cnt[0] + w_cnt[1]) + 1));
        for (int m = 0; m < MASTER_COUNT; m++) begin
            if (range_first[m] !== exp_setup[m].first_addr)
                report_mismatch($sformatf("range_first[%0d]", m), range_first[m],
                                exp_setup[m].first_addr);
            if (range_last[m] !== exp_setup[m].last_addr)
                report_mismatch($sformatf("range_last[%0d]", m), range_last[m],
                                exp_setup[m].last_addr);
        end
    endtask

    task automatic check_comm();
        int cyc;
        logic all_done;
        for (int n = 0; n < 2; n++) begin
            @(negedge clk);
            for (int m = 0; m < MASTER_COUNT; m++)
                if (cmd[m].start !== (n == 0))              // one cycle only
                    report_mismatch($sformatf("cmd[%0d].start", m), cmd[m].start, n == 0);
        end
        all_done = &done_com;
        for (cyc = 0; cyc < 40 && !comm_done; cyc++) begin
            @(negedge clk);
            if (comm_done !== all_done)
                report_mismatch("comm_done", comm_done, all_done);
            all_done = &done_com;
        end
        if (!comm_done)
            report_error("comm_done never rose after the masters were started");
    endtask

    task automatic check_readback(input word_t value);
        @(negedge clk);
        for (int m = 0; m < MASTER_COUNT; m++)
            if (cmd[m].address !== value[ADDR_WIDTH-1:0])
                report_mismatch($sformatf("cmd[%0d].address", m), cmd[m].address,
                                value[ADDR_WIDTH-1:0]);
        @(negedge clk);
        for (int m = 0; m < MASTER_COUNT; m++)
            if (read_data[m] !== {4'(m + 1), value[ADDR_WIDTH-1:0]})
                report_mismatch($sformatf("read_data[%0d]", m), read_data[m],
                                {4'(m + 1), value[ADDR_WIDTH-1:0]});
    endtask

    initial begin
        #($size(rows) * 40 * 100);
        $display("ERROR: run timed out with %0d errors so far", errors);
        $display("Something failed");
        $finish;
    end

    initial begin
        errors = 0;
        lfsr = 16'd80;
        clk = 1'b0;
        rstN = 1'b0;
        step = 1'b0;
        addr_step = 1'b0;
        sw = '0;
        rows[0] = '{16'h0007, 1'b0, plain_row, 3'b000};    // master 0 on slave 3, master 1 on 1
        rows[1] = '{16'h0001, 1'b0, plain_row, 3'b000};    // rd_wr per master
        rows[2] = '{16'h0001, 1'b0, plain_row, 3'b000};    // bank entry for master 0 only
        for (int k = 0; k < 4; k++) begin
            bank[k] = random_word();
            rows[3 + k] = '{bank[k], 1'b1, plain_row, 3'b000};
        end
        rows[7] = '{16'h0000, 1'b0, plain_row, 3'b000};
        rows[8] = '{16'd2000, 1'b0, plain_row, 3'b000};    // first addresses
        rows[9] = '{16'd100, 1'b0, plain_row, 3'b000};
        rows[10] = '{16'd100, 1'b0, plain_row, 3'b000};    // master 0 length
        rows[11] = '{16'd0, 1'b0, config_row, 3'b010};     // zero length keeps master 1 single
        rows[12] = '{16'd0, 1'b0, comm_row, 3'b001};
        rows[13] = '{16'h0123, 1'b1, readback_row, 3'b001};
        rows[14] = '{16'h0abc, 1'b1, readback_row, 3'b001};
        rows[15] = '{16'h07ff, 1'b1, readback_row, 3'b001};
        for (int m = 0; m < MASTER_COUNT; m++) begin
            exp_setup[m].slave_id = rows[0].sw[2*m +: 2];
            exp_setup[m].rd_wr = rows[1].sw[m];
            exp_setup[m].in_ex = rows[2].sw[m];
            exp_setup[m].burst = (rows[10 + m].sw != 0);
            exp_setup[m].first_addr = rows[8 + m].sw[ADDR_WIDTH-1:0];
            w_cnt[m] = (exp_setup[m].in_ex && m == 0) ? $size(bank) : 2;
        end
        exp_setup[0].last_addr = 12'd2047;     // 2000 + 100 runs past the 2048 words of slave 3
        exp_setup[1].last_addr = 12'd100;

        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        if ({at_start, config_ready, comm_done} !== 3'b100)
            report_mismatch("{at_start,config_ready,comm_done}",
                            {at_start, config_ready, comm_done}, 3'b100);
        for (int m = 0; m < MASTER_COUNT; m++)
            if (cmd[m].start !== 1'b0)
                report_mismatch($sformatf("cmd[%0d].start", m), cmd[m].start, 1'b0);

        foreach (rows[i]) begin
            apply_strobe(rows[i]);
            case (rows[i].kind)
                config_row:   check_config();
                comm_row:     check_comm();
                readback_row: check_readback(rows[i].sw);
                default:      @(negedge clk);
            endcase
            if ({at_start, config_ready, comm_done} !== rows[i].status)
                report_mismatch("{at_start,config_ready,comm_done}",
                                {at_start, config_ready, comm_done}, rows[i].status);
        end

        $display("%0d errors over %0d table rows", errors, $size(rows));
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
